// ==== include/csr_index_macros.svh ====
// ----------------------------------------------------------
// CSR index engine widths and sizes
//   index, address and granularity shift widths
//   request queue depth and stall threshold
//   initial output credits
// ----------------------------------------------------------

`ifndef CSR_INDEX_MACROS_SVH
`define CSR_INDEX_MACROS_SVH

// Datapath widths
`define CSR_INDEX_W 32
`define CSR_ADDR_W 32
`define CSR_SHIFT_W 5

// Request queue sizing
`define CSR_QUEUE_DEPTH 8
// Generator holds its index at this fill level
`define CSR_QUEUE_AFULL 6

// Requests the engine may have in flight toward memory
`define CSR_CREDITS 4

`endif

// ==== src/csr_index_pkg.sv ====
// ----------------------------------------------------------
// CSR index engine types
//   vector typedefs for index, address and shift
//   configuration beat, job parameters, read request
//   control FSM states
// ----------------------------------------------------------

`include "csr_index_macros.svh"

package csr_index_pkg;

    typedef logic [`CSR_INDEX_W-1:0] index_t;
    typedef logic [`CSR_ADDR_W-1:0]  addr_t;
    typedef logic [`CSR_SHIFT_W-1:0] shift_t;

    // Field tag carried by each configuration beat
    typedef enum logic [2:0] {
        FIELD_DIRECTION = 3'd0,
        FIELD_START     = 3'd1,
        FIELD_END       = 3'd2,
        FIELD_BASE      = 3'd3,
        FIELD_SHIFT     = 3'd4
    } config_field_e;

    // For FIELD_DIRECTION, data[0] set selects decrement
    typedef struct packed {
        logic          valid;
        config_field_e field;
        logic [31:0]   data;
    } config_word_t;

    typedef struct packed {
        logic   decrement;
        index_t index_start;
        index_t index_end;
        addr_t  base;
        shift_t shift;
    } engine_config_t;

    typedef struct packed {
        logic   valid;
        addr_t  addr;
        index_t index;
    } mem_request_t;

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        BUSY,
        DONE
    } engine_state_e;

endpackage

// ==== src/csr_index_config.sv ====
// ----------------------------------------------------------
// Configuration capture
//   one register per job field, written by tagged beats
//   presence mask, cleared when the controller takes a job
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_index_config
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_engine_csr_index,
    input  config_word_t   config_in,
    input  logic           take,
    output engine_config_t cfg,
    output logic           config_ready
);

    logic [4:0] field_present;
    logic [4:0] beat_hit;

    // Which field the current beat writes, none for unknown tags
    always_comb begin
        beat_hit = 5'b0;
        if (config_in.valid) begin
            case (config_in.field)
                FIELD_DIRECTION: beat_hit[0] = 1'b1;
                FIELD_START:     beat_hit[1] = 1'b1;
                FIELD_END:       beat_hit[2] = 1'b1;
                FIELD_BASE:      beat_hit[3] = 1'b1;
                FIELD_SHIFT:     beat_hit[4] = 1'b1;
                default:         beat_hit = 5'b0;
            endcase
        end
    end

    // ------------------------------------------------------
    // Presence tracking
    // ------------------------------------------------------
    // A beat landing with take counts toward the next job
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            field_present <= 5'b0;
        end else if (take) begin
            field_present <= beat_hit;
        end else begin
            field_present <= field_present | beat_hit;
        end
    end

    assign config_ready = &field_present;

    // ------------------------------------------------------
    // Field registers, last write wins
    // ------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (beat_hit[0]) cfg.decrement   <= config_in.data[0];
        if (beat_hit[1]) cfg.index_start <= config_in.data[$bits(index_t)-1:0];
        if (beat_hit[2]) cfg.index_end   <= config_in.data[$bits(index_t)-1:0];
        if (beat_hit[3]) cfg.base        <= config_in.data[$bits(addr_t)-1:0];
        if (beat_hit[4]) cfg.shift       <= config_in.data[$bits(shift_t)-1:0];
    end

endmodule

// ==== src/csr_index_generator.sv ====
// ----------------------------------------------------------
// Request generator
//   latches one job on load
//   walks the index range up or down, one step per cycle
//   forms address = base + (index << shift)
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_index_generator
    import csr_index_pkg::*;
(
    input  logic           ap_clk,
    input  logic           areset_engine_csr_index,
    input  logic           load,
    input  engine_config_t cfg,
    input  logic           stall,
    output mem_request_t   request,
    output logic           finished
);

    logic   active;
    logic   decrement_q;
    index_t index_q;
    index_t index_end_q;
    addr_t  base_q;
    shift_t shift_q;

    index_t index_next;
    logic   range_open;
    logic   more_after_step;
    logic   issue;

    // Empty or inverted ranges never become active
    assign range_open = cfg.decrement ? (cfg.index_start > cfg.index_end)
                                      : (cfg.index_start < cfg.index_end);

    assign index_next = decrement_q ? index_q - 1'b1 : index_q + 1'b1;

    assign more_after_step = decrement_q ? (index_next > index_end_q)
                                         : (index_next < index_end_q);

    // Hold the current index while the queue is near full
    assign issue = active & ~stall;

    // ------------------------------------------------------
    // Range state
    // ------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            active <= 1'b0;
        end else if (load) begin
            active <= range_open;
        end else if (issue) begin
            active <= more_after_step;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (load) begin
            decrement_q <= cfg.decrement;
            index_q     <= cfg.index_start;
            index_end_q <= cfg.index_end;
            base_q      <= cfg.base;
            shift_q     <= cfg.shift;
        end else if (issue) begin
            index_q <= index_next;
        end
    end

    // ------------------------------------------------------
    // Request toward the queue
    // ------------------------------------------------------
    always_comb begin
        request.valid = issue;
        request.addr  = base_q + (addr_t'(index_q) << shift_q);
        request.index = index_q;
    end

    assign finished = ~active;

endmodule

// ==== src/csr_index_request_queue.sv ====
// ----------------------------------------------------------
// Request queue
//   circular FIFO with fill count and almost-full flag
//   credit counter gating issue to the memory side
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "csr_index_macros.svh"

module csr_index_request_queue
    import csr_index_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_engine_csr_index,
    input  mem_request_t push,
    output logic         almost_full,
    output logic         empty,
    output mem_request_t request_out,
    input  logic         credit_return
);

    localparam int PTR_W    = $clog2(`CSR_QUEUE_DEPTH);
    localparam int COUNT_W  = $clog2(`CSR_QUEUE_DEPTH + 1);
    localparam int CREDIT_W = $clog2(`CSR_CREDITS + 1);

    addr_t  mem_addr  [`CSR_QUEUE_DEPTH];
    index_t mem_index [`CSR_QUEUE_DEPTH];

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic [COUNT_W-1:0]  count;
    logic [CREDIT_W-1:0] credits;
    logic                pop;
    logic                out_valid;
    addr_t               out_addr;
    index_t              out_index;

    // Issue needs both a queued entry and a credit
    assign pop         = (count != '0) && (credits != '0);
    assign empty       = (count == '0);
    assign almost_full = (count >= COUNT_W'(`CSR_QUEUE_AFULL));

    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            credits   <= CREDIT_W'(`CSR_CREDITS);
            out_valid <= 1'b0;
        end else begin
            if (push.valid) wr_ptr <= wr_ptr + 1'b1;
            if (pop) rd_ptr <= rd_ptr + 1'b1;
            case ({push.valid, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({credit_return, pop})
                2'b10:   credits <= credits + 1'b1;
                2'b01:   credits <= credits - 1'b1;
                default: credits <= credits;
            endcase
            out_valid <= pop;
        end
    end

    // Storage and output payload
    always_ff @(posedge ap_clk) begin
        if (push.valid) begin
            mem_addr[wr_ptr]  <= push.addr;
            mem_index[wr_ptr] <= push.index;
        end
        if (pop) begin
            out_addr  <= mem_addr[rd_ptr];
            out_index <= mem_index[rd_ptr];
        end
    end

    always_comb begin
        request_out.valid = out_valid;
        request_out.addr  = out_addr;
        request_out.index = out_index;
    end

endmodule

// ==== src/csr_index_control.sv ====
// ----------------------------------------------------------
// Job controller
//   IDLE -> LOAD -> BUSY -> DONE state machine
//   registered take and done pulses
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_index_control
    import csr_index_pkg::*;
(
    input  logic ap_clk,
    input  logic areset_engine_csr_index,
    input  logic start,
    input  logic config_ready,
    input  logic finished,
    input  logic queue_empty,
    output logic take,
    output logic done
);

    engine_state_e state;
    engine_state_e next_state;

    // ------------------------------------------------------
    // State register
    // ------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    // ------------------------------------------------------
    // Next state
    // ------------------------------------------------------
    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                // Start is only looked at here
                if (start && config_ready && finished) begin
                    next_state = LOAD;
                end
            end
            LOAD: begin
                next_state = BUSY;
            end
            BUSY: begin
                // Generator drained and last request has left
                if (finished && queue_empty) begin
                    next_state = DONE;
                end
            end
            DONE: begin
                next_state = IDLE;
            end
            default: begin
                next_state = IDLE;
            end
        endcase
    end

    // Outputs line up with the LOAD and DONE cycles
    always_ff @(posedge ap_clk) begin
        if (areset_engine_csr_index) begin
            take <= 1'b0;
            done <= 1'b0;
        end else begin
            take <= (next_state == LOAD);
            done <= (next_state == DONE);
        end
    end

endmodule

// ==== src/csr_index_engine.sv ====
// ----------------------------------------------------------
// CSR index request engine, top level
//   configuration capture -> generator -> request queue
//   job controller alongside
// ----------------------------------------------------------

`timescale 1ns/1ps

module csr_index_engine
    import csr_index_pkg::*;
(
    input  logic         ap_clk,
    input  logic         areset_engine_csr_index,
    input  config_word_t config_in,
    input  logic         start,
    output mem_request_t request_out,
    input  logic         credit_return,
    output logic         done
);

    engine_config_t cfg;
    logic           config_ready;
    logic           take;
    mem_request_t   gen_request;
    logic           finished;
    logic           almost_full;
    logic           queue_empty;

    csr_index_config i_config (
        .ap_clk                  (ap_clk),
        .areset_engine_csr_index (areset_engine_csr_index),
        .config_in               (config_in),
        .take                    (take),
        .cfg                     (cfg),
        .config_ready            (config_ready)
    );

    csr_index_generator i_generator (
        .ap_clk                  (ap_clk),
        .areset_engine_csr_index (areset_engine_csr_index),
        .load                    (take),
        .cfg                     (cfg),
        .stall                   (almost_full),
        .request                 (gen_request),
        .finished                (finished)
    );

    csr_index_request_queue i_queue (
        .ap_clk                  (ap_clk),
        .areset_engine_csr_index (areset_engine_csr_index),
        .push                    (gen_request),
        .almost_full             (almost_full),
        .empty                   (queue_empty),
        .request_out             (request_out),
        .credit_return           (credit_return)
    );

    csr_index_control i_control (
        .ap_clk                  (ap_clk),
        .areset_engine_csr_index (areset_engine_csr_index),
        .start                   (start),
        .config_ready            (config_ready),
        .finished                (finished),
        .queue_empty             (queue_empty),
        .take                    (take),
        .done                    (done)
    );

endmodule

// ==== sim/csr_index_engine_assert.sv ====
// ----------------------------------------------------------
// Concurrent assertions for the CSR index engine
//   outputs quiet after reset
//   done lasts a single cycle
//   no issue without an output credit
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "csr_index_macros.svh"

module csr_index_engine_assert
    import csr_index_pkg::*;
(
    input logic                                ap_clk,
    input logic                                areset_engine_csr_index,
    input logic                                done,
    input mem_request_t                        request_out,
    input logic [$clog2(`CSR_CREDITS + 1)-1:0] queue_credits
);

    quiet_after_reset: assert property (@(posedge ap_clk)
        areset_engine_csr_index |=> (!done && !request_out.valid))
        else $error("done or request valid high after reset");

    single_done: assert property (@(posedge ap_clk) disable iff (areset_engine_csr_index)
        done |=> !done)
        else $error("done high on two consecutive cycles");

    // Issue decision is made one cycle before the request appears
    credit_gated: assert property (@(posedge ap_clk) disable iff (areset_engine_csr_index)
        request_out.valid |-> ($past(queue_credits) != '0))
        else $error("request issued with zero credits");

endmodule

bind csr_index_engine csr_index_engine_assert i_assert (
    .ap_clk                  (ap_clk),
    .areset_engine_csr_index (areset_engine_csr_index),
    .done                    (done),
    .request_out             (request_out),
    .queue_credits           (i_queue.credits)
);

// ==== sim/tb_csr_index_engine.sv ====
// ----------------------------------------------------------
// Testbench for the CSR index request engine
//   clock, reset and falling-edge stimulus
//   credit return model with LFSR delays
//   directed tests for ranges, credits and configuration
//   typed compare tasks and closing error count
// ----------------------------------------------------------

`timescale 1ns/1ps
`include "csr_index_macros.svh"

module tb_csr_index_engine
    import csr_index_pkg::*;
;

    logic         ap_clk = 1'b0;
    logic         areset_engine_csr_index;
    config_word_t config_in;
    logic         start;
    mem_request_t request_out;
    logic         credit_return = 1'b0;
    logic         done;

    logic         hold_credits = 1'b0;
    logic [31:0]  lfsr_state = 32'hbba6;
    int unsigned  cycle_count = 0;
    int unsigned  delay;
    int unsigned  return_due[$];
    mem_request_t seen_q[$];
    int           done_count = 0;
    int           mismatch_count = 0;
    int           other_errors = 0;

    csr_index_engine i_dut (
        .ap_clk                  (ap_clk),
        .areset_engine_csr_index (areset_engine_csr_index),
        .config_in               (config_in),
        .start                   (start),
        .request_out             (request_out),
        .credit_return           (credit_return),
        .done                    (done)
    );

    always #5 ap_clk = ~ap_clk;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic next_random_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    // ------------------------------------------------------
    // Output monitor and credit return model
    // ------------------------------------------------------
    always @(negedge ap_clk) begin
        credit_return = 1'b0;
        if (!areset_engine_csr_index) begin
            if (request_out.valid) begin
                seen_q.push_back(request_out);
                // Return one to four cycles later
                delay = 1;
                if (next_random_bit()) delay = delay + 1;
                if (next_random_bit()) delay = delay + 2;
                return_due.push_back(cycle_count + delay);
            end
            if (done) done_count++;
            if (!hold_credits && return_due.size() > 0) begin
                if (return_due[0] <= cycle_count) begin
                    void'(return_due.pop_front());
                    credit_return = 1'b1;
                end
            end
        end
        cycle_count++;
    end

    // ------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------
    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic check_index(input string name, input index_t got, input index_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_done_pulse();
        if (done_count != 1) begin
            other_errors++;
            $display("Expected one done pulse at %0t, saw %0d", $time, done_count);
        end
    endtask

    task automatic check_requests(input logic dec, input index_t s, input index_t e,
                                  input addr_t base, input shift_t shift);
        int     expected;
        index_t exp_index;
        addr_t  exp_addr;
        addr_t  scale;
        if (dec) begin
            expected = (s > e) ? int'(s - e) : 0;
        end else begin
            expected = (s < e) ? int'(e - s) : 0;
        end
        if (seen_q.size() != expected) begin
            other_errors++;
            $display("Wrong request count at %0t: saw %0d, expected %0d",
                     $time, seen_q.size(), expected);
        end
        // Granularity as a power of two
        scale = addr_t'(1);
        for (int k = 0; k < int'(shift); k++) begin
            scale = scale * 2;
        end
        for (int i = 0; i < seen_q.size() && i < expected; i++) begin
            exp_index = dec ? s - index_t'(i) : s + index_t'(i);
            exp_addr  = base + addr_t'(exp_index) * scale;
            check_index($sformatf("request_out.index[%0d]", i), seen_q[i].index, exp_index);
            check_addr($sformatf("request_out.addr[%0d]", i), seen_q[i].addr, exp_addr);
        end
    endtask

    // ------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------
    task automatic write_field(input config_field_e f, input logic [31:0] d);
        config_in.valid = 1'b1;
        config_in.field = f;
        config_in.data  = d;
        @(negedge ap_clk);
        config_in.valid = 1'b0;
    endtask

    task automatic write_job(input logic dec, input index_t s, input index_t e,
                             input addr_t base, input shift_t shift);
        write_field(FIELD_DIRECTION, {31'b0, dec});
        write_field(FIELD_START, s);
        write_field(FIELD_END, e);
        write_field(FIELD_BASE, base);
        write_field(FIELD_SHIFT, {27'b0, shift});
    endtask

    task automatic begin_job();
        seen_q.delete();
        done_count = 0;
        start = 1'b1;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!done && n < limit) begin
            @(negedge ap_clk);
            n++;
        end
        if (!done) begin
            other_errors++;
            $display("Timeout at %0t: no done pulse within %0d cycles", $time, limit);
        end
    endtask

    task automatic expect_quiet(input int cycles, input string what);
        bit seen;
        seen = 1'b0;
        for (int n = 0; n < cycles; n++) begin
            @(negedge ap_clk);
            if (request_out.valid || done) seen = 1'b1;
        end
        if (seen) begin
            other_errors++;
            $display("Request or done appeared %s at %0t", what, $time);
        end
    endtask

    task automatic finish_job(input logic dec, input index_t s, input index_t e,
                              input addr_t base, input shift_t shift);
        wait_done(400);
        start = 1'b0;
        // Let stray requests or pulses show up
        for (int n = 0; n < 6; n++) begin
            @(negedge ap_clk);
        end
        check_done_pulse();
        check_requests(dec, s, e, base, shift);
    endtask

    // ------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------
    task automatic test_ascending_range();
        write_job(1'b0, 3, 11, 32'h1000, 2);
        begin_job();
        finish_job(1'b0, 3, 11, 32'h1000, 2);
    endtask

    task automatic test_descending_range();
        write_job(1'b1, 40, 30, 32'h0001_0000, 5);
        begin_job();
        finish_job(1'b1, 40, 30, 32'h0001_0000, 5);
    endtask

    task automatic test_credit_backpressure();
        write_job(1'b0, 0, 16, 32'h8000, 3);
        hold_credits = 1'b1;
        begin_job();
        for (int n = 0; n < 40; n++) begin
            @(negedge ap_clk);
        end
        if (seen_q.size() > `CSR_CREDITS) begin
            other_errors++;
            $display("%0d requests issued with credits withheld", seen_q.size());
        end
        hold_credits = 1'b0;
        finish_job(1'b0, 0, 16, 32'h8000, 3);
    endtask

    task automatic test_incomplete_config();
        write_field(FIELD_DIRECTION, 32'h0);
        write_field(FIELD_START, 32'd0);
        write_field(FIELD_END, 32'd5);
        write_field(FIELD_BASE, 32'h4000_0000);
        begin_job();
        expect_quiet(40, "with only four fields written");
        write_field(FIELD_SHIFT, 32'd4);
        finish_job(1'b0, 0, 5, 32'h4000_0000, 4);
    endtask

    task automatic test_overwrite_and_reuse();
        write_field(FIELD_DIRECTION, 32'h0);
        write_field(FIELD_START, 32'd100);
        write_field(FIELD_END, 32'd104);
        write_field(FIELD_BASE, 32'h5000);
        write_field(FIELD_SHIFT, 32'd1);
        write_field(FIELD_BASE, 32'h2000);
        begin_job();
        finish_job(1'b0, 100, 104, 32'h2000, 1);
        // Old fields must not start a second job
        begin_job();
        expect_quiet(30, "before the second job was configured");
        write_job(1'b1, 7, 7, 32'h9000, 2);
        finish_job(1'b1, 7, 7, 32'h9000, 2);
    endtask

    // ------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------
    initial begin
        areset_engine_csr_index = 1'b1;
        config_in = '0;
        start = 1'b0;
        repeat (4) @(negedge ap_clk);
        areset_engine_csr_index = 1'b0;
        @(negedge ap_clk);
        test_ascending_range();
        test_descending_range();
        test_credit_backpressure();
        test_incomplete_config();
        test_overwrite_and_reuse();
        $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Overall limit on simulated time
    initial begin
        #200000;
        $display("Simulation time limit reached before the tests finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+include
src/csr_index_pkg.sv
src/csr_index_config.sv
src/csr_index_generator.sv
src/csr_index_request_queue.sv
src/csr_index_control.sv
src/csr_index_engine.sv
sim/csr_index_engine_assert.sv
sim/tb_csr_index_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the CSR index engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --top-module tb_csr_index_engine \
    -f vlog.f \
    -Mdir obj_dir \
    -o tb_csr_index_engine

if ! ./obj_dir/tb_csr_index_engine > sim.log 2>&1; then
    cat sim.log
    echo "Simulation exited with an error status"
    exit 1
fi

cat sim.log

if grep -q '\*\* FAIL \*\*' sim.log; then
    exit 1
fi
exit 0
